// ==== Makefile ====
# Verilator flow for the sprite chip testbench
TOP = tb_k051960

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps \
		-f project.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f project.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== cpu_regs.sv ====
// CPU register port
// Strobe decode, control register, status read, interrupt flops and attribute writes
`include "k051960_cfg.svh"
`default_nettype none

module cpu_regs
	import k051960_pkg::*;
(
	input  logic       clk_6M,
	input  logic       RES_SYNC,
	input  cpu_bus_t   bus,
	input  timing_t    timing,
	output logic [7:0] rdata,
	output ctrl_reg_t  ctrl,
	output attr_wr_t   attr_wr,
	output logic       irq,
	output logic       nmi
);

	logic       reg_sel;
	logic       attr_sel;
	logic       ctrl_hit;
	logic       ctrl_wr;
	logic       ctrl_rd;
	logic       vblank_q;
	logic       vblank_rise;
	logic [7:0] line_num;
	logic       nmi_tick;

	// Address decode
	assign reg_sel  = ~bus.addr[10] & (bus.addr[9:3] == 7'd0);
	assign attr_sel = bus.addr[10] & ~bus.addr[9];
	assign ctrl_hit = reg_sel & (bus.addr[2:0] == 3'(`K_REG_CTRL));
	assign ctrl_wr  = bus.cs & bus.we & ctrl_hit;
	assign ctrl_rd  = bus.cs & ~bus.we & ctrl_hit;

	// Attribute RAM is only writable in vblank
	assign attr_wr.en       = bus.cs & bus.we & attr_sel & timing.vblank;
	assign attr_wr.sprite   = bus.addr[8:2];
	assign attr_wr.byte_sel = attr_byte_e'(bus.addr[1:0]);
	assign attr_wr.data     = bus.wdata;

	always_ff @(posedge clk_6M or negedge RES_SYNC) begin
		if (!RES_SYNC) begin
			ctrl <= '0;
		end else if (ctrl_wr) begin
			ctrl <= ctrl_reg_t'(bus.wdata);
		end
	end

	// Status byte, vblank in bit 0
	always_ff @(posedge clk_6M or negedge RES_SYNC) begin
		if (!RES_SYNC)
			rdata <= 8'h00;
		else
			rdata <= ctrl_rd ? {7'd0, timing.vblank} : 8'h00;
	end

	always_ff @(posedge clk_6M or negedge RES_SYNC) begin
		if (!RES_SYNC)
			vblank_q <= 1'b0;
		else
			vblank_q <= timing.vblank;
	end

	assign vblank_rise = timing.vblank & ~vblank_q;

	// Undo the screen flip to get the raw line count
	assign line_num = timing.vp ^ {8{ctrl.flip}};
	assign nmi_tick = (timing.h == 9'd0) &
		(line_num[`K_NMI_PERIOD_LOG2-1:0] == '0);

	// Interrupts hold until their enable drops
	always_ff @(posedge clk_6M or negedge RES_SYNC) begin
		if (!RES_SYNC) begin
			irq <= 1'b0;
			nmi <= 1'b0;
		end else begin
			if (!ctrl.irq_en)
				irq <= 1'b0;
			else if (vblank_rise)
				irq <= 1'b1;

			if (!ctrl.nmi_en)
				nmi <= 1'b0;
			else if (nmi_tick)
				nmi <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== k051960_cfg.svh ====
// Sprite chip configuration
// Video timing, attribute RAM size and register map
`ifndef K051960_CFG_SVH
`define K051960_CFG_SVH

`default_nettype none

// Raster timing in pixel clocks and lines
`define K_H_TOTAL 384
`define K_V_TOTAL 264
`define K_V_ACTIVE 224   // First blanked line

// Attribute RAM
`define K_SPRITES 128

// NMI every 2**5 lines
`define K_NMI_PERIOD_LOG2 5

// Register map
`define K_REG_CTRL 0

`default_nettype wire

`endif

// ==== k051960_pkg.sv ====
// Shared types for the sprite chip
// CPU strobe bus, attribute writes, control register and timing bundle
`default_nettype none

package k051960_pkg;

	// CPU strobe bus, sampled on one clock edge
	typedef struct packed {
		logic        cs;
		logic        we;
		logic [10:0] addr;
		logic [7:0]  wdata;
	} cpu_bus_t;

	// Byte lanes of one attribute entry
	typedef enum logic [1:0] {
		ATTR_Y       = 2'd0,
		ATTR_FLAGS   = 2'd1,
		ATTR_CODE_LO = 2'd2,
		ATTR_CODE_HI = 2'd3
	} attr_byte_e;

	// Sprite height, 16 << size
	typedef enum logic [1:0] {
		SIZE_16  = 2'd0,
		SIZE_32  = 2'd1,
		SIZE_64  = 2'd2,
		SIZE_128 = 2'd3
	} spr_size_e;

	typedef struct packed {
		logic       en;
		logic [6:0] sprite;
		attr_byte_e byte_sel;
		logic [7:0] data;
	} attr_wr_t;

	// Register 0 layout, bit 7 down to bit 0
	typedef struct packed {
		logic [1:0] spare_76;
		logic       nmi_en;
		logic       spare_4;
		logic       flip;
		logic       spare_2;
		logic       irq_en;
		logic       spare_0;
	} ctrl_reg_t;

	typedef struct packed {
		logic [8:0] h;
		logic [7:0] vp;     // Line number, flipped if requested
		logic       vblank;
		logic       hend;
	} timing_t;

	// Tile ROM address
	typedef struct packed {
		logic [10:0] code;
		logic [6:0]  row;
	} rom_addr_t;

endpackage

`default_nettype wire

// ==== k051960_sva.sv ====
// Bound assertions on the sprite chip top level
// Blanking, interrupt, end of line and attribute write rules
`default_nettype none

module k051960_sva
	import k051960_pkg::*;
(
	input logic     clk_6M,
	input logic     RES_SYNC,
	input logic     vblank,
	input logic     hend,
	input logic     ca_valid,
	input logic     irq,
	input attr_wr_t attr_wr
);

	timeunit 1ns;
	timeprecision 1ps;

	// Scan pipeline has drained once blanking has settled
	a_no_ca_in_vblank: assert property (@(posedge clk_6M) disable iff (!RES_SYNC)
		vblank && $past(vblank) && $past(vblank, 2) |-> !ca_valid)
		else $error("tile address valid deep in vertical blank");

	a_irq_in_vblank: assert property (@(posedge clk_6M) disable iff (!RES_SYNC)
		$rose(irq) |-> vblank)
		else $error("irq rose outside vertical blank");

	a_hend_pulse: assert property (@(posedge clk_6M) disable iff (!RES_SYNC)
		hend |=> !hend)
		else $error("end of line strobe longer than one cycle");

	// Gated write enable from the register block
	a_attr_wr_vblank: assert property (@(posedge clk_6M) disable iff (!RES_SYNC)
		attr_wr.en |-> vblank)
		else $error("attribute RAM write outside vertical blank");

endmodule

`default_nettype wire

// ==== k051960_top.sv ====
// Sprite chip top level
// Timing and CPU registers side by side, feeding the sprite line scanner
`default_nettype none

module k051960_top
	import k051960_pkg::*;
(
	input  logic       clk_6M,
	input  logic       RES_SYNC,
	input  cpu_bus_t   bus,
	output logic [7:0] rdata,
	output logic [7:0] vp,
	output logic       vblank,
	output logic       hend,
	output rom_addr_t  ca,
	output logic       ca_valid,
	output logic       irq,
	output logic       nmi
);

	timing_t   timing;
	ctrl_reg_t ctrl;
	attr_wr_t  attr_wr;

	video_timing u_timing (
		.clk_6M   (clk_6M),
		.RES_SYNC (RES_SYNC),
		.flip     (ctrl.flip),
		.timing   (timing)
	);

	cpu_regs u_regs (
		.clk_6M   (clk_6M),
		.RES_SYNC (RES_SYNC),
		.bus      (bus),
		.timing   (timing),
		.rdata    (rdata),
		.ctrl     (ctrl),
		.attr_wr  (attr_wr),
		.irq      (irq),
		.nmi      (nmi)
	);

	sprite_line_gen u_sprites (
		.clk_6M   (clk_6M),
		.RES_SYNC (RES_SYNC),
		.attr_wr  (attr_wr),
		.timing   (timing),
		.ca       (ca),
		.ca_valid (ca_valid)
	);

	// Raster outputs
	assign vp     = timing.vp;
	assign vblank = timing.vblank;
	assign hend   = timing.hend;

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+.
k051960_pkg.sv
video_timing.sv
cpu_regs.sv
sprite_line_gen.sv
k051960_top.sv
k051960_sva.sv
tb_k051960.sv

// ==== sprite_line_gen.sv ====
// Sprite line scanner
// Attribute RAM plus a two-stage scan that emits a tile ROM address per line hit
`include "k051960_cfg.svh"
`default_nettype none

module sprite_line_gen
	import k051960_pkg::*;
(
	input  logic      clk_6M,
	input  logic      RES_SYNC,
	input  attr_wr_t  attr_wr,
	input  timing_t   timing,
	output rom_addr_t ca,
	output logic      ca_valid
);

	// Four bytes per sprite, indexed by attr_byte_e
	logic [3:0][7:0] attr_ram [`K_SPRITES];

	logic            scan_en;
	logic            s1_valid;
	logic [3:0][7:0] s1_entry;
	logic [7:0]      s1_vp;

	spr_size_e       size;
	logic [7:0]      height;
	logic [7:0]      row_raw;
	logic [7:0]      row_sel;
	logic            active;
	logic            vflip;
	logic            hit;
	logic [10:0]     code;

	// One sprite per pixel clock at the start of each visible line
	assign scan_en = ~timing.vblank & (timing.h < 9'(`K_SPRITES));

	// RAM write port and stage 1 read
	always_ff @(posedge clk_6M) begin
		if (attr_wr.en)
			attr_ram[attr_wr.sprite][attr_wr.byte_sel] <= attr_wr.data;
		s1_entry <= attr_ram[timing.h[6:0]];
		s1_vp    <= timing.vp;
	end

	always_ff @(posedge clk_6M or negedge RES_SYNC) begin
		if (!RES_SYNC)
			s1_valid <= 1'b0;
		else
			s1_valid <= scan_en;
	end

	// Stage 2, line test and tile row
	assign active = s1_entry[ATTR_FLAGS][7];
	assign vflip  = s1_entry[ATTR_FLAGS][2];
	assign size   = spr_size_e'(s1_entry[ATTR_FLAGS][1:0]);

	always_comb begin
		unique case (size)
			SIZE_16:  height = 8'd16;
			SIZE_32:  height = 8'd32;
			SIZE_64:  height = 8'd64;
			SIZE_128: height = 8'd128;
		endcase
	end

	assign row_raw = s1_vp - s1_entry[ATTR_Y];   // Wraps mod 256
	assign hit     = active & (row_raw < height);
	assign row_sel = vflip ? (height - 8'd1 - row_raw) : row_raw;
	assign code    = {s1_entry[ATTR_CODE_HI][2:0], s1_entry[ATTR_CODE_LO]};

	always_ff @(posedge clk_6M or negedge RES_SYNC) begin
		if (!RES_SYNC)
			ca_valid <= 1'b0;
		else
			ca_valid <= s1_valid & hit;
	end

	// Address payload only loads on a hit
	always_ff @(posedge clk_6M) begin
		if (s1_valid & hit) begin
			ca.code <= code;
			ca.row  <= row_sel[6:0];  // Below height, so fits 7 bits
		end
	end

endmodule

`default_nettype wire

// ==== tb_k051960.sv ====
// Testbench for the sprite chip
// Loads a sprite table, scans chosen lines and checks tile addresses and interrupts
`include "k051960_cfg.svh"
`default_nettype none

module tb_k051960
	import k051960_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int FRAME        = `K_H_TOTAL * `K_V_TOTAL;
	localparam int LINE_TIMEOUT = FRAME + `K_H_TOTAL;
	localparam int N_SPR        = 11;

	typedef struct packed {
		logic [6:0] sprite;
		logic [7:0] y;
		spr_size_e  size;
		logic       vflip;
		logic       active;
		logic       exp_hit;   // Outcome on line 100
	} spr_entry_t;

	localparam spr_entry_t SPR_TABLE [N_SPR] = '{
		'{7'd3,   8'd95,  SIZE_16,  1'b0, 1'b1, 1'b1},
		'{7'd10,  8'd90,  SIZE_16,  1'b1, 1'b1, 1'b1},   // Flipped row 5
		'{7'd20,  8'd50,  SIZE_64,  1'b0, 1'b1, 1'b1},
		'{7'd30,  8'd40,  SIZE_128, 1'b1, 1'b1, 1'b1},
		'{7'd40,  8'd80,  SIZE_32,  1'b0, 1'b1, 1'b1},
		'{7'd50,  8'd101, SIZE_16,  1'b0, 1'b1, 1'b0},   // Starts one line below
		'{7'd60,  8'd95,  SIZE_16,  1'b0, 1'b0, 1'b0},   // Inactive
		'{7'd70,  8'd60,  SIZE_32,  1'b0, 1'b1, 1'b0},
		'{7'd90,  8'd150, SIZE_16,  1'b0, 1'b1, 1'b0},   // Only on the flipped screen
		'{7'd100, 8'd140, SIZE_32,  1'b1, 1'b1, 1'b0},
		'{7'd127, 8'd250, SIZE_128, 1'b0, 1'b1, 1'b1}    // Wraps past line 255
	};

	logic       clk_6M;
	logic       RES_SYNC;
	cpu_bus_t   bus;
	logic [7:0] rdata;
	logic [7:0] vp;
	logic       vblank;
	logic       hend;
	rom_addr_t  ca;
	logic       ca_valid;
	logic       irq;
	logic       nmi;

	int          errors;
	int          timeouts;
	logic [31:0] lfsr_q;
	logic [10:0] codes [N_SPR];
	rom_addr_t   exp_q [$];
	rom_addr_t   got_q [$];
	int          exp_at [$];
	int          got_at [$];

	k051960_top dut (
		.clk_6M   (clk_6M),
		.RES_SYNC (RES_SYNC),
		.bus      (bus),
		.rdata    (rdata),
		.vp       (vp),
		.vblank   (vblank),
		.hend     (hend),
		.ca       (ca),
		.ca_valid (ca_valid),
		.irq      (irq),
		.nmi      (nmi)
	);

	bind k051960_top k051960_sva u_sva (
		.clk_6M   (clk_6M),
		.RES_SYNC (RES_SYNC),
		.vblank   (vblank),
		.hend     (hend),
		.ca_valid (ca_valid),
		.irq      (irq),
		.attr_wr  (attr_wr)
	);

	initial begin
		clk_6M = 1'b0;
		forever #2 clk_6M = ~clk_6M;
	end

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
		lfsr_q = {lfsr_q[30:0], fb};
		return fb;
	endfunction

	function automatic logic [10:0] rand_code();
		logic [10:0] c = '0;
		for (int i = 0; i < 11; i++)
			c = {c[9:0], lfsr_bit()};
		return c;
	endfunction

	// Line model, returns {hit, code, row}
	function automatic logic [18:0] model_addr(spr_entry_t e, logic [10:0] code,
		logic [7:0] line);
		logic [7:0] height;
		logic [7:0] row;
		logic       hit;
		height = 8'd16 << e.size;
		row    = line - e.y;
		hit    = e.active && (row < height);
		if (e.vflip)
			row = height - 8'd1 - row;
		return {hit, code, row[6:0]};
	endfunction

	task automatic tick();
		@(negedge clk_6M);
	endtask

	task automatic finish_run();
		$display("Check summary: %0d value errors, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	endtask

	task automatic abort_run(input string what);
		$display("ERROR at %0t: timed out, %s", $time, what);
		timeouts++;
		finish_run();
	endtask

	task automatic check_val(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got == exp) else begin
			errors++;
			$display("FAIL t=%0t %s: got %0h, expected %0h", $time, name, got, exp);
		end
	endtask

	// One strobe, sampled on the next rising edge
	task automatic write_bus(input logic [10:0] addr, input logic [7:0] data);
		bus.cs    = 1'b1;
		bus.we    = 1'b1;
		bus.addr  = addr;
		bus.wdata = data;
		tick();
		bus = '0;
	endtask

	task automatic write_attr(input logic [6:0] sprite, input attr_byte_e sel,
		input logic [7:0] data);
		write_bus({1'b1, 1'b0, sprite, sel}, data);
	endtask

	task automatic write_ctrl(input logic [7:0] data);
		write_bus(11'(`K_REG_CTRL), data);
	endtask

	// Status byte carries vblank as seen at the strobe edge
	task automatic read_status(input logic exp_vb);
		bus.cs    = 1'b1;
		bus.we    = 1'b0;
		bus.addr  = 11'(`K_REG_CTRL);
		tick();
		bus = '0;
		check_val("rdata", 32'(rdata), 32'(exp_vb));
	endtask

	task automatic wait_vblank_rise(output int cycles);
		logic prev;
		cycles = 0;
		do begin
			prev = vblank;
			tick();
			cycles++;
			if (cycles > LINE_TIMEOUT)
				abort_run("vblank never rose");
		end while (!(vblank && !prev));
	endtask

	// End of line strobe sits on the last pixel, the line steps right after
	task automatic check_line_end();
		int         n;
		logic [7:0] line;
		n = 0;
		while (!hend) begin
			tick();
			n++;
			if (n > `K_H_TOTAL)
				abort_run("hend never asserted");
		end
		line = vp;
		tick();
		check_val("vp", 32'(vp), 32'(line + 8'd1));
		n = 1;
		while (!hend) begin
			tick();
			n++;
			if (n > `K_H_TOTAL)
				abort_run("hend did not repeat");
		end
		check_val("hend period", n, `K_H_TOTAL);
	endtask

	task automatic wait_level(input logic use_nmi, input logic level, input int limit,
		input string what);
		int n;
		n = 0;
		while ((use_nmi ? nmi : irq) != level) begin
			tick();
			n++;
			if (n > limit)
				abort_run(what);
		end
	endtask

	// Returns at h = 0 of the next visit to the line
	task automatic wait_line(input logic [7:0] line);
		int n;
		n = 0;
		while (vp == line) begin
			tick();
			n++;
			if (n > `K_H_TOTAL)
				abort_run("line number stuck on target");
		end
		n = 0;
		while (vp != line) begin
			tick();
			n++;
			if (n > LINE_TIMEOUT)
				abort_run("target line never reached");
		end
	endtask

	task automatic load_table();
		for (int s = 0; s < `K_SPRITES; s++)
			write_attr(7'(s), ATTR_FLAGS, 8'h00);   // RAM has no reset
		for (int i = 0; i < N_SPR; i++) begin
			codes[i] = rand_code();
			write_attr(SPR_TABLE[i].sprite, ATTR_Y, SPR_TABLE[i].y);
			write_attr(SPR_TABLE[i].sprite, ATTR_FLAGS, {SPR_TABLE[i].active, 4'd0,
				SPR_TABLE[i].vflip, SPR_TABLE[i].size});
			write_attr(SPR_TABLE[i].sprite, ATTR_CODE_LO, codes[i][7:0]);
			write_attr(SPR_TABLE[i].sprite, ATTR_CODE_HI, {5'd0, codes[i][10:8]});
		end
	endtask

	task automatic build_expected(input logic [7:0] line);
		logic [18:0] r;
		exp_q.delete();
		exp_at.delete();
		for (int i = 0; i < N_SPR; i++) begin
			r = model_addr(SPR_TABLE[i], codes[i], line);
			if (r[18]) begin
				exp_q.push_back(rom_addr_t'(r[17:0]));
				exp_at.push_back(int'(SPR_TABLE[i].sprite) + 1);   // Sample i is at h = i + 1
			end
		end
	endtask

	// Scan of sprite k shows up two clocks after h = k
	task automatic scan_and_compare(input logic [7:0] line);
		wait_line(line);
		got_q.delete();
		got_at.delete();
		for (int i = 0; i < `K_SPRITES + 8; i++) begin
			tick();
			if (ca_valid) begin
				got_q.push_back(ca);
				got_at.push_back(i);
			end
		end
		check_val("ca_valid count", got_q.size(), exp_q.size());
		foreach (exp_q[i])
			if (i < got_q.size()) begin
				check_val("ca", 32'(got_q[i]), 32'(exp_q[i]));
				check_val("ca_valid cycle", got_at[i], exp_at[i]);
			end
	endtask

	initial begin
		int          cycles;
		logic [18:0] r;
		lfsr_q   = 32'h31f6_cfe4;
		errors   = 0;
		timeouts = 0;
		bus      = '0;
		RES_SYNC = 1'b0;
		repeat (8) tick();
		RES_SYNC = 1'b1;

		check_val("irq", 32'(irq), 32'd0);
		check_val("nmi", 32'(nmi), 32'd0);
		check_val("ca_valid", 32'(ca_valid), 32'd0);
		wait_vblank_rise(cycles);
		check_val("cycles to vblank", cycles, `K_V_ACTIVE * `K_H_TOTAL);
		wait_vblank_rise(cycles);
		check_val("cycles per frame", cycles, FRAME);
		read_status(1'b1);
		check_line_end();

		load_table();
		for (int i = 0; i < N_SPR; i++) begin
			r = model_addr(SPR_TABLE[i], codes[i], 8'd100);
			assert (r[18] == SPR_TABLE[i].exp_hit) else begin
				errors++;
				$display("ERROR: table entry %0d disagrees with the line model", i);
			end
		end
		build_expected(8'd100);
		scan_and_compare(8'd100);
		read_status(1'b0);

		// Write during active display must be dropped
		check_val("vblank", 32'(vblank), 32'd0);
		write_attr(7'd5, ATTR_Y, 8'd95);
		write_attr(7'd5, ATTR_FLAGS, 8'h80);
		write_attr(7'd5, ATTR_CODE_LO, 8'h5a);
		write_attr(7'd5, ATTR_CODE_HI, 8'h03);
		scan_and_compare(8'd100);

		// Still early on line 100
		check_val("vp", 32'(vp), 32'd100);
		write_ctrl(8'h08);
		check_val("vp", 32'(vp), {24'd0, ~8'd100});
		build_expected(~8'd100);
		scan_and_compare(~8'd100);

		write_ctrl(8'h02);   // irq_en, flip off
		wait_vblank_rise(cycles);
		wait_level(1'b0, 1'b1, 4, "irq never rose in vblank");
		write_ctrl(8'h00);
		wait_level(1'b0, 1'b0, 4, "irq never cleared");

		write_ctrl(8'h20);
		wait_level(1'b1, 1'b1, ((1 << `K_NMI_PERIOD_LOG2) + 1) * `K_H_TOTAL,
			"nmi never rose");
		write_ctrl(8'h00);
		wait_level(1'b1, 1'b0, 4, "nmi never cleared");

		finish_run();
	end

endmodule

`default_nettype wire

// ==== video_timing.sv ====
// Video timing generator
// Pixel and line counters, vertical blank, end of line and flipped line number
`include "k051960_cfg.svh"
`default_nettype none

module video_timing
	import k051960_pkg::*;
(
	input  logic    clk_6M,
	input  logic    RES_SYNC,
	input  logic    flip,
	output timing_t timing
);

	logic [8:0] h;
	logic [8:0] v;
	logic       h_last;
	logic       v_last;

	assign h_last = (h == 9'(`K_H_TOTAL - 1));
	assign v_last = (v == 9'(`K_V_TOTAL - 1));

	// Pixel counter
	always_ff @(posedge clk_6M or negedge RES_SYNC) begin
		if (!RES_SYNC) begin
			h <= 9'd0;
		end else if (h_last) begin
			h <= 9'd0;
		end else begin
			h <= h + 9'd1;
		end
	end

	// Line counter steps on the pixel wrap
	always_ff @(posedge clk_6M or negedge RES_SYNC) begin
		if (!RES_SYNC) begin
			v <= 9'd0;
		end else if (h_last) begin
			if (v_last)
				v <= 9'd0;
			else
				v <= v + 9'd1;
		end
	end

	assign timing.h      = h;
	assign timing.hend   = h_last;
	assign timing.vblank = (v >= 9'(`K_V_ACTIVE));

	// Screen flip inverts every line bit
	assign timing.vp = v[7:0] ^ {8{flip}};

endmodule

`default_nettype wire
